// ==== Makefile ====
# Verilator build and run for the audio delay testbench.

VERILATOR ?= verilator
TOP       ?= tb_audio_delay
LINT_TOP  ?= audio_delay
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS  := $(filter verilog/%,$(shell cat $(FILELIST)))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/delay_checker.sv ====
`timescale 1ns/10ps

module delay_checker
    import delay_pkg::*;
    (
        input  logic                           clk,
        input  logic                           rst,
        input  logic [pot_width-1:0]           pot_wet,
        input  logic [pot_width-1:0]           pot_rate,
        input  logic [pot_width-1:0]           pot_feedback,
        input  logic signed [sample_width-1:0] sample_in,
        input  logic                           sample_in_valid,
        input  logic signed [sample_width-1:0] sample_out,
        input  logic                           sample_out_valid,

        input  logic                           test_active,
        input  logic                           test_done,
        input  logic [63:0]                    test_name,
        input  int                             exp_count,
        input  logic [31:0]                    exp_xor,

        output int                             error_count,
        output int                             tests_passed,
        output int                             tests_failed
    );

    logic signed [sample_width-1:0] model_mem [delay_depth];
    longint                         sample_index; // Samples since the last reset.
    int                             cycle = 0;
    int                             due_q[$];
    int                             value_q[$];
    logic                           rst_q = 1'b0;
    logic                           active_q = 1'b0;
    int                             test_outputs;
    logic [sample_width-1:0]        test_xor;
    int                             error_base;

    initial begin
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    function automatic longint clamp_sample(input longint value);
        if (value > sample_max) begin
            return sample_max;
        end else if (value < sample_min) begin
            return sample_min;
        end
        return value;
    endfunction

    always @(posedge clk) begin : compare
        longint x;
        longint d;
        longint w;
        longint y;
        int     pw;
        int     pf;
        int     gw;
        int     dlen;
        int     expected;
        cycle++;
        if (test_active && !active_q) begin
            test_outputs = 0;
            test_xor     = '0;
            error_base   = error_count;
        end
        if (rst) begin
            due_q.delete();
            value_q.delete();
            sample_index = 0;
            if (!rst_q) begin
                for (int i = 0; i < delay_depth; i++) begin
                    model_mem[i] = '0;
                end
            end
        end else begin
            if (rst_q && sample_out_valid) begin
                $display("sample_out_valid was high on the first cycle after reset");
                error_count++;
            end
            if (rst_q && sample_out !== '0) begin
                $display("error: sample_out after reset expected 0000, got %h", sample_out);
                error_count++;
            end
            if (sample_out_valid && test_active) begin
                test_outputs++;
                test_xor ^= sample_out;
            end
            if (sample_out_valid) begin
                if (due_q.size() == 0 || due_q[0] != cycle) begin
                    $display("sample_out_valid pulsed at cycle %0d with no sample due", cycle);
                    error_count++;
                end else begin
                    void'(due_q.pop_front());
                    expected = value_q.pop_front();
                    if (sample_out !== sample_width'(expected)) begin
                        $display("error: sample_out expected %h, got %h",
                                 sample_width'(expected), sample_out);
                        error_count++;
                    end
                end
            end
            if (due_q.size() > 0 && due_q[0] < cycle) begin
                $display("no output 4 cycles after the input at cycle %0d", due_q[0] - 4);
                void'(due_q.pop_front());
                void'(value_q.pop_front());
                error_count++;
            end
            if (sample_in_valid) begin
                x    = sample_in;
                pw   = pot_wet;
                pf   = pot_feedback;
                dlen = (gain_unity - int'(pot_rate)) << delay_scale_shift;
                gw   = (pw >= wet_full_threshold) ? gain_unity : pw;
                d    = 0; // Nothing has been written that far back yet.
                if (sample_index >= dlen) begin
                    d = model_mem[int'((sample_index - dlen) % delay_depth)];
                end
                w = clamp_sample(x + ((d * pf) >>> gain_shift));
                y = clamp_sample((x * (gain_unity - gw) + d * gw) >>> gain_shift);
                model_mem[int'(sample_index % delay_depth)] = sample_width'(w);
                sample_index++;
                due_q.push_back(cycle + 4);
                value_q.push_back(int'(y));
            end
        end
        if (test_done) begin
            if (test_outputs != exp_count) begin
                $display("error: output count expected %h, got %h", exp_count, test_outputs);
                error_count++;
            end
            // Bit 16 of the summary marks a test whose outputs are only checked one by one.
            if (!exp_xor[16] && test_xor != exp_xor[sample_width-1:0]) begin
                $display("error: sample_out xor expected %h, got %h",
                         exp_xor[sample_width-1:0], test_xor);
                error_count++;
            end
            if (error_count == error_base) begin
                tests_passed++;
                $display("test %0s passed: %0d outputs, xor %h", test_name, test_outputs,
                         test_xor);
            end else begin
                tests_failed++;
                $display("test %0s failed with %0d errors", test_name, error_count - error_base);
            end
        end
        active_q = test_active;
        rst_q    = rst;
    end

endmodule

// ==== bench/tb_audio_delay.sv ====
`timescale 1ns/10ps

module tb_audio_delay
    import delay_pkg::*;
    ();

    logic                           clk;
    logic                           rst;
    logic [pot_width-1:0]           pot_wet;
    logic [pot_width-1:0]           pot_rate;
    logic [pot_width-1:0]           pot_feedback;
    logic signed [sample_width-1:0] sample_in;
    logic                           sample_in_valid;
    logic signed [sample_width-1:0] sample_out;
    logic                           sample_out_valid;

    logic        test_active;
    logic        test_done;
    logic [63:0] test_name;
    int          exp_count;
    logic [31:0] exp_xor;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    int          cycle_count;
    int          cycle_limit;
    int          num_tests;
    logic        load_ok;

    logic [63:0] names[$];
    logic [63:0] patterns[$];
    logic [31:0] xors[$];
    int          wet_pots[$];
    int          rate_pots[$];
    int          rate2_pots[$];
    int          feedback_pots[$];
    int          counts[$];
    int          amps[$];
    int          out_counts[$];

    audio_delay u_audio_delay (
        .clk              (clk),
        .rst              (rst),
        .pot_wet          (pot_wet),
        .pot_rate         (pot_rate),
        .pot_feedback     (pot_feedback),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

    delay_checker u_delay_checker (
        .clk              (clk),
        .rst              (rst),
        .pot_wet          (pot_wet),
        .pot_rate         (pot_rate),
        .pot_feedback     (pot_feedback),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .test_active      (test_active),
        .test_done        (test_done),
        .test_name        (test_name),
        .exp_count        (exp_count),
        .exp_xor          (exp_xor),
        .error_count      (error_count),
        .tests_passed     (tests_passed),
        .tests_failed     (tests_failed)
    );

    always #20 clk = ~clk; // 40 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic load_tests();
        int          fd;
        int          fields;
        string       line;
        logic [63:0] name;
        logic [63:0] pat;
        logic [31:0] xor_value;
        int          pw;
        int          pr;
        int          pr2;
        int          pf;
        int          cnt;
        int          amp;
        int          outs;
        fd = $fopen("delay_stim.txt", "r");
        load_ok = (fd != 0);
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %d %d %s %d %d %h", name, pw, pr, pr2,
                                     pf, cnt, pat, amp, outs, xor_value);
                    if (fields == 10) begin
                        names.push_back(name);
                        wet_pots.push_back(pw);
                        rate_pots.push_back(pr);
                        rate2_pots.push_back(pr2);
                        feedback_pots.push_back(pf);
                        counts.push_back(cnt);
                        patterns.push_back(pat);
                        amps.push_back(amp);
                        out_counts.push_back(outs);
                        xors.push_back(xor_value);
                    end else begin
                        $display("could not parse a line of delay_stim.txt: %s", line);
                        load_ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = names.size();
        if (num_tests == 0) begin
            load_ok = 1'b0;
        end
    endtask

    // Input sample number s of a test, built from the pattern named in the stimulus file.
    function automatic int pattern_value(input logic [63:0] pat, input int amp, input int s);
        logic signed [sample_width-1:0] wrapped;
        int                             value;
        value = 0;
        if (pat == "impulse") begin
            value = (s == 0) ? amp : 0;
        end else if (pat == "constant") begin
            value = amp;
        end else if (pat == "ramp") begin
            wrapped = sample_width'(s * amp);
            value = wrapped;
        end else if (pat == "random") begin
            value = int'($urandom % (2 * amp + 1)) - amp;
        end
        return value;
    endfunction

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // One strobe, then idle until the next six-cycle slot.
    task automatic drive_sample(input int value, input int pw, input int pr, input int pf);
        @(posedge clk);
        pot_wet         <= pot_width'(pw);
        pot_rate        <= pot_width'(pr);
        pot_feedback    <= pot_width'(pf);
        sample_in       <= sample_width'(value);
        sample_in_valid <= 1'b1;
        @(posedge clk);
        sample_in_valid <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic run_test(input int i);
        int rate;
        if (i > 0) begin
            apply_reset(); // Zeros over the words the previous test wrote.
            for (int s = 0; s < counts[i-1]; s++) begin
                drive_sample(0, 0, 1023, 0);
            end
        end
        apply_reset();
        test_name   <= names[i];
        exp_count   <= out_counts[i];
        exp_xor     <= xors[i];
        test_active <= 1'b1;
        for (int s = 0; s < counts[i]; s++) begin
            rate = (s >= counts[i] / 2) ? rate2_pots[i] : rate_pots[i];
            drive_sample(pattern_value(patterns[i], amps[i], s), wet_pots[i], rate,
                         feedback_pots[i]);
        end
        @(posedge clk);
        test_active <= 1'b0;
        test_done   <= 1'b1;
        @(posedge clk);
        test_done   <= 1'b0;
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        pot_wet         = '0;
        pot_rate        = '0;
        pot_feedback    = '0;
        sample_in       = '0;
        sample_in_valid = 1'b0;
        test_active     = 1'b0;
        test_done       = 1'b0;
        test_name       = '0;
        exp_count       = 0;
        exp_xor         = '0;
        cycle_count     = 0;
        cycle_limit     = 0;
        void'($urandom(32'h0502_87f3));
        load_tests();
        if (!load_ok) begin
            $display("no usable test vectors were read from delay_stim.txt");
            $display("TEST FAILED");
        end else begin
            // Each test costs its own samples, a flush of the previous ones and two resets.
            cycle_limit = 200;
            for (int i = 0; i < num_tests; i++) begin
                cycle_limit += (counts[i] + ((i > 0) ? counts[i-1] : 0)) * 6 + 16;
            end
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            @(posedge clk);
            $display("%0d tests, %0d passed, %0d failed, %0d errors", num_tests, tests_passed,
                     tests_failed, error_count);
            if (tests_failed == 0 && error_count == 0 && tests_passed == num_tests) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== delay_stim.txt ====
# name wet rate rate2 feedback count pattern amplitude out_count out_xor
# rate2 takes over from sample count/2 on; out_xor 10000 means the xor is not checked.
#
# Dry path, wet pot at zero so every output equals its input.
t01 0 1000 1000 0 40 impulse 12345 40 03039
t02 0 1023 1023 512 131 constant -1000 131 0fc18
t03 0 980 980 0 67 ramp 256 67 04300
t04 0 900 900 300 100 random 32767 100 10000
#
# Full wet, no feedback, so the impulse comes back once after 64 or 128 samples.
t05 1023 1023 1023 0 128 impulse 20000 128 04e20
t06 1023 1022 1022 0 200 impulse 20000 200 04e20
#
# Half feedback, each echo is half the one before.
t07 1020 1023 1023 512 320 impulse 16384 320 07800
#
# Mid-range mix on noise.
t08 400 1010 1010 600 300 random 20000 300 10000
#
# Full feedback on large constants drives the memory into both clamps.
t09 700 1023 1023 1023 193 constant 30000 193 07c93
t10 700 1023 1023 1023 193 constant -30000 193 0836b
#
# Rate moves from 64 to 128 samples at sample 100, half mix.
t11 512 1023 1022 0 200 impulse 16384 200 02000

// ==== project.f ====
verilog/delay_pkg.sv
verilog/delay_ram.sv
verilog/pot_mapper.sv
verilog/delay_line.sv
verilog/wet_dry_mixer.sv
verilog/audio_delay.sv
bench/delay_checker.sv
bench/tb_audio_delay.sv

// ==== verilog/audio_delay.sv ====
`timescale 1ns/10ps

module audio_delay
    import delay_pkg::*;
    (
        input  logic                           clk,
        input  logic                           rst,

        input  logic [pot_width-1:0]           pot_wet,
        input  logic [pot_width-1:0]           pot_rate,
        input  logic [pot_width-1:0]           pot_feedback,

        input  logic signed [sample_width-1:0] sample_in,
        input  logic                           sample_in_valid,

        output logic signed [sample_width-1:0] sample_out,
        output logic                           sample_out_valid
    );

    logic signed [sample_width-1:0] dry_sample;
    logic [addr_width:0]            delay_len;
    logic [gain_width-1:0]          wet_gain;
    logic [gain_width-1:0]          feedback_gain;
    logic                           map_valid;

    logic [addr_width-1:0]          rd_addr;
    logic signed [sample_width-1:0] rd_data;
    logic [addr_width-1:0]          wr_addr;
    logic signed [sample_width-1:0] wr_data;
    logic                           wr_en;

    logic signed [sample_width-1:0] delayed_sample;
    logic                           delayed_valid;

    pot_mapper u_pot_mapper (
        .clk             (clk),
        .rst             (rst),
        .pot_wet         (pot_wet),
        .pot_rate        (pot_rate),
        .pot_feedback    (pot_feedback),
        .sample_in       (sample_in),
        .sample_in_valid (sample_in_valid),
        .dry_sample      (dry_sample),
        .delay_len       (delay_len),
        .wet_gain        (wet_gain),
        .feedback_gain   (feedback_gain),
        .map_valid       (map_valid)
    );

    delay_line u_delay_line (
        .clk            (clk),
        .rst            (rst),
        .map_valid      (map_valid),
        .dry_sample     (dry_sample),
        .delay_len      (delay_len),
        .feedback_gain  (feedback_gain),
        .rd_data        (rd_data),
        .rd_addr        (rd_addr),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_en          (wr_en),
        .delayed_sample (delayed_sample),
        .delayed_valid  (delayed_valid)
    );

    delay_ram u_delay_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    // The mapper holds the dry sample and gain until the next strobe, long past the mix.
    wet_dry_mixer u_wet_dry_mixer (
        .clk              (clk),
        .rst              (rst),
        .delayed_valid    (delayed_valid),
        .dry_sample       (dry_sample),
        .delayed_sample   (delayed_sample),
        .wet_gain         (wet_gain),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

endmodule

// ==== verilog/delay_line.sv ====
`timescale 1ns/10ps

module delay_line
    import delay_pkg::*;
    (
        input  logic                           clk,
        input  logic                           rst,

        input  logic                           map_valid,
        input  logic signed [sample_width-1:0] dry_sample,
        input  logic [addr_width:0]            delay_len,
        input  logic [gain_width-1:0]          feedback_gain,

        input  logic signed [sample_width-1:0] rd_data,
        output logic [addr_width-1:0]          rd_addr,
        output logic [addr_width-1:0]          wr_addr,
        output logic signed [sample_width-1:0] wr_data,
        output logic                           wr_en,

        output logic signed [sample_width-1:0] delayed_sample,
        output logic                           delayed_valid
    );

    logic [addr_width-1:0]        write_ptr;
    logic [1:0]                   valid_pipe; // Matches the two read stages of the memory.
    logic signed [acc_width-1:0]  fb_product;
    logic signed [acc_width-1:0]  fb_sum;

    // A full 65536 sample delay wraps onto the write pointer itself.
    assign rd_addr = write_ptr - delay_len[addr_width-1:0];
    assign wr_addr = write_ptr;

    assign delayed_valid  = valid_pipe[1];
    assign delayed_sample = rd_data;

    assign fb_product = acc_width'(rd_data) * acc_width'($signed({1'b0, feedback_gain}));
    assign fb_sum     = acc_width'(dry_sample) + (fb_product >>> gain_shift);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], map_valid};
        end
    end

    // The echo is written one cycle after the read returns, then the pointer moves on.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en     <= 1'b0;
            write_ptr <= '0;
        end else begin
            wr_en <= delayed_valid;
            if (wr_en) begin
                write_ptr <= write_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (delayed_valid) begin
            wr_data <= saturate(fb_sum);
        end
    end

endmodule

// ==== verilog/delay_pkg.sv ====
package delay_pkg;

    localparam int sample_width = 16;
    localparam int pot_width = 10;
    localparam int gain_width = 11;
    localparam int gain_shift = 10;
    localparam int gain_unity = 1 << gain_shift;

    localparam int delay_depth = 65536;
    localparam int addr_width = 16;
    localparam int delay_scale_shift = 6; // Delay length is the rate span times 64.

    localparam int wet_full_threshold = 1016; // Top of the wet pot snaps to unity.

    localparam int sample_max = 32767;
    localparam int sample_min = -32768;

    // Wide enough for any product of a sample and a gain, plus a sum of two.
    localparam int acc_width = 2 * sample_width;

    // Clamps a wide signed value into the audio sample range.
    function automatic logic signed [sample_width-1:0] saturate(
        input logic signed [acc_width-1:0] value
    );
        logic signed [sample_width-1:0] result;
        if (value > acc_width'(sample_max)) begin
            result = sample_width'(sample_max);
        end else if (value < acc_width'(sample_min)) begin
            result = sample_width'(sample_min);
        end else begin
            result = value[sample_width-1:0];
        end
        return result;
    endfunction

endpackage

// ==== verilog/delay_ram.sv ====
`timescale 1ns/10ps

module delay_ram
    import delay_pkg::*;
    (
        input  logic                           clk,

        input  logic [addr_width-1:0]          rd_addr,
        output logic signed [sample_width-1:0] rd_data,

        input  logic [addr_width-1:0]          wr_addr,
        input  logic signed [sample_width-1:0] wr_data,
        input  logic                           wr_en
    );

    logic signed [sample_width-1:0] mem [delay_depth];
    logic signed [sample_width-1:0] array_q; // First read stage, straight out of the array.

    // Simulation starts from silence, as a freshly configured block RAM does.
    initial begin
        for (int i = 0; i < delay_depth; i++) begin
            mem[i] = '0;
        end
    end

    // The read and the write share one edge, so a colliding read sees the old word.
    always_ff @(posedge clk) begin
        array_q <= mem[rd_addr];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= array_q; // Output register.
    end

endmodule

// ==== verilog/pot_mapper.sv ====
`timescale 1ns/10ps

module pot_mapper
    import delay_pkg::*;
    (
        input  logic                           clk,
        input  logic                           rst,

        input  logic [pot_width-1:0]           pot_wet,
        input  logic [pot_width-1:0]           pot_rate,
        input  logic [pot_width-1:0]           pot_feedback,

        input  logic signed [sample_width-1:0] sample_in,
        input  logic                           sample_in_valid,

        output logic signed [sample_width-1:0] dry_sample,
        output logic [addr_width:0]            delay_len,
        output logic [gain_width-1:0]          wet_gain,
        output logic [gain_width-1:0]          feedback_gain,
        output logic                           map_valid
    );

    logic [gain_width-1:0] rate_span;
    logic [addr_width:0]   next_delay_len;
    logic [gain_width-1:0] next_wet_gain;

    // A full-up rate pot gives the shortest delay, span 1, and zero gives 1024.
    assign rate_span = gain_width'(gain_unity) - {1'b0, pot_rate};
    assign next_delay_len = {rate_span, {delay_scale_shift{1'b0}}};

    assign next_wet_gain = (pot_wet >= wet_full_threshold) ? gain_width'(gain_unity)
                                                           : {1'b0, pot_wet};

    always_ff @(posedge clk) begin
        if (rst) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= sample_in_valid;
        end
    end

    // Settings are held from one sample to the next, so a pot move lands on a sample boundary.
    always_ff @(posedge clk) begin
        if (sample_in_valid) begin
            dry_sample    <= sample_in;
            delay_len     <= next_delay_len;
            wet_gain      <= next_wet_gain;
            feedback_gain <= {1'b0, pot_feedback};
        end
    end

endmodule

// ==== verilog/wet_dry_mixer.sv ====
`timescale 1ns/10ps

module wet_dry_mixer
    import delay_pkg::*;
    (
        input  logic                           clk,
        input  logic                           rst,

        input  logic                           delayed_valid,
        input  logic signed [sample_width-1:0] dry_sample,
        input  logic signed [sample_width-1:0] delayed_sample,
        input  logic [gain_width-1:0]          wet_gain,

        output logic signed [sample_width-1:0] sample_out,
        output logic                           sample_out_valid
    );

    logic [gain_width-1:0]       dry_gain;
    logic signed [acc_width-1:0] dry_term;
    logic signed [acc_width-1:0] wet_term;
    logic signed [acc_width-1:0] mix_acc;

    // The two gains always add up to unity, so the mix is a true crossfade.
    assign dry_gain = gain_width'(gain_unity) - wet_gain;

    assign dry_term = acc_width'(dry_sample) * acc_width'($signed({1'b0, dry_gain}));
    assign wet_term = acc_width'(delayed_sample) * acc_width'($signed({1'b0, wet_gain}));
    assign mix_acc  = (dry_term + wet_term) >>> gain_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out       <= '0;
            sample_out_valid <= 1'b0;
        end else begin
            sample_out_valid <= delayed_valid;
            if (delayed_valid) begin
                sample_out <= saturate(mix_acc); // Held until the next sample.
            end
        end
    end

endmodule
